/* filelist.f */
titan_pkg.sv
titan_if_stage.sv
titan_id_stage.sv
titan_ex_stage.sv
titan_lsu.sv
titan_control_unit.sv
titan_core.sv
tb_titan_core.sv

/* run.sh */
#!/bin/sh
# Build and run the titan core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --timescale 1ns/10ps --top-module tb_titan_core \
	-f filelist.f -o sim_titan > build.log 2>&1 &&
./obj_dir/sim_titan > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "PASSED" || { echo "FAILED, see build.log and sim.log"; exit 1; }

/* tb_titan_core.sv */
/*
 * titan core testbench
 * Runs a small RV32I program on the core with randomly delayed
 * instruction and data bus acknowledges, and compares every store
 * against an ISA-level model of the same program.
 */
`timescale 1ns/10ps

module tb_titan_core;
	import titan_pkg::*;

	logic        clk_i    = 1'b0;
	logic        arst_n_i = 1'b0;
	logic [31:0] iaddr_o;
	logic        ireq_o;
	logic [31:0] idat_i   = 32'h0;
	logic        iack_i   = 1'b0;
	logic [31:0] daddr_o;
	logic        dreq_o;
	logic        dwe_o;
	logic [31:0] dwdat_o;
	logic [31:0] drdat_i  = 32'h0;
	logic        dack_i   = 1'b0;

	logic [31:0] prog [64];
	logic [31:0] dmem [64];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] loop_addr;
	integer      seed = 79;
	int          prog_len = 0;
	int          loop_fetches = 0;
	int          cycles;
	int          i_wait;
	int          d_wait;
	logic        i_armed;
	logic        d_armed;
	logic        dreq_seen = 1'b0;

	titan_core dut0 (
		.clk_i   (clk_i),
		.arst_n_i(arst_n_i),
		.iaddr_o (iaddr_o),
		.ireq_o  (ireq_o),
		.idat_i  (idat_i),
		.iack_i  (iack_i),
		.daddr_o (daddr_o),
		.dreq_o  (dreq_o),
		.dwe_o   (dwe_o),
		.dwdat_o (dwdat_o),
		.drdat_i (drdat_i),
		.dack_i  (dack_i)
	);

	always #50 clk_i = ~clk_i;

	// ------------------------------
	// Instruction encoding
	// ------------------------------
	function automatic logic [31:0] reg_op(logic [31:0] f7, logic [31:0] rs2,
			logic [31:0] rs1, logic [31:0] f3, logic [31:0] rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] imm_op(logic [31:0] f3, logic [31:0] rd,
			logic [31:0] rs1, logic [31:0] imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
	endfunction

	function automatic logic [31:0] upper_imm(logic [31:0] rd, logic [31:0] imm);
		return {imm[19:0], rd[4:0], 7'h37};
	endfunction

	function automatic logic [31:0] load_w(logic [31:0] rd, logic [31:0] rs1,
			logic [31:0] off);
		return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
	endfunction

	function automatic logic [31:0] store_w(logic [31:0] rs2, logic [31:0] rs1,
			logic [31:0] off);
		return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] cond_branch(logic [31:0] f3, logic [31:0] rs1,
			logic [31:0] rs2, logic [31:0] off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			7'h63};
	endfunction

	function automatic logic [31:0] jump_link(logic [31:0] rd, logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	// Initial data memory contents as a hash of the byte address
	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	task automatic load_program();
		for (int k = 0; k < 64; k++) begin
			prog[k] = imm_op(0, 0, 0, 0);
		end
		emit(upper_imm(1, 32'h80001));
		emit(imm_op(3'b000, 2, 0, -5));
		emit(imm_op(3'b000, 3, 2, 12));
		emit(reg_op(7'h20, 2, 3, 3'b000, 4));
		emit(store_w(4, 0, 0));
		emit(store_w(1, 0, 4));
		emit(reg_op(0, 3, 2, 3'b010, 5));
		emit(imm_op(3'b010, 6, 3, -1));
		emit(imm_op(3'b010, 7, 2, -3));
		emit(store_w(5, 0, 8));
		emit(reg_op(0, 7, 6, 3'b000, 8));
		emit(store_w(8, 0, 12));
		emit(reg_op(0, 2, 1, 3'b111, 9));
		emit(reg_op(0, 3, 9, 3'b100, 10));
		emit(reg_op(0, 2, 10, 3'b110, 11));
		emit(imm_op(3'b111, 12, 11, 32'h7f3));
		emit(imm_op(3'b110, 13, 12, -256));
		emit(imm_op(3'b100, 14, 13, 32'h5a5));
		emit(store_w(14, 0, 16));
		// Load-use pairs
		emit(load_w(15, 0, 16));
		emit(reg_op(0, 10, 15, 3'b000, 16));
		emit(store_w(16, 0, 20));
		emit(load_w(17, 0, 64));
		emit(reg_op(0, 16, 17, 3'b100, 18));
		emit(store_w(18, 0, 24));
		// Taken BEQ skips two stores
		emit(cond_branch(3'b000, 5, 7, 12));
		emit(store_w(2, 0, 28));
		emit(store_w(3, 0, 28));
		emit(cond_branch(3'b001, 6, 0, 8));
		emit(store_w(4, 0, 32));
		emit(jump_link(19, 12));
		emit(store_w(2, 0, 36));
		emit(store_w(3, 0, 36));
		emit(store_w(19, 0, 36));
		// Park here
		emit(jump_link(0, 0));
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic void run_model();
		logic [31:0] x [32];
		logic [31:0] mem [64];
		logic [31:0] pc;
		logic [31:0] nxt;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] i_imm;
		logic [31:0] s_imm;
		logic [31:0] b_imm;
		logic [31:0] j_imm;
		logic [2:0]  f3;
		logic        wen;
		int          k;
		int          steps;
		for (k = 0; k < 32; k++) begin
			x[k] = 32'h0;
		end
		for (k = 0; k < 64; k++) begin
			mem[k] = fill_word(32'(k * 4));
		end
		pc = RESET_ADDR;
		steps = 0;
		while (steps < 1000) begin
			ins = prog[pc[7:2]];
			f3 = ins[14:12];
			a = x[ins[19:15]];
			b = x[ins[24:20]];
			i_imm = $signed(ins) >>> 20;
			s_imm = {i_imm[31:5], ins[11:7]};
			b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			nxt = pc + 32'd4;
			wen = 1'b0;
			res = 32'h0;
			case (ins[6:0])
				7'h37: begin
					res = {ins[31:12], 12'h000};
					wen = 1'b1;
				end
				7'h13, 7'h33: begin
					if (ins[6:0] == 7'h13) begin
						b = i_imm;
					end
					case (f3)
						3'b000:  res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
						3'b010:  res = 32'($signed(a) < $signed(b));
						3'b100:  res = a ^ b;
						3'b110:  res = a | b;
						3'b111:  res = a & b;
						default: res = 32'h0;
					endcase
					wen = 1'b1;
				end
				7'h63: begin
					if ((a == b) != f3[0]) begin
						nxt = pc + b_imm;
					end
				end
				7'h6f: begin
					res = pc + 32'd4;
					wen = 1'b1;
					nxt = pc + j_imm;
				end
				7'h03: begin
					addr = a + i_imm;
					res = mem[addr[7:2]];
					wen = 1'b1;
				end
				7'h23: begin
					addr = a + s_imm;
					mem[addr[7:2]] = b;
					exp_addr.push_back({addr[31:2], 2'b00});
					exp_data.push_back(b);
				end
				default: begin
					wen = 1'b0;
				end
			endcase
			if (wen && ins[11:7] != 5'd0) begin
				x[ins[11:7]] = res;
			end
			// Jump to self ends the program
			if (nxt == pc) begin
				break;
			end
			pc = nxt;
			steps++;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR: %s is %h, expected %h", name, got, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ------------------------------
	// Bus models
	// ------------------------------
	always @(posedge clk_i) begin
		if (!arst_n_i) begin
			iack_i  <= 1'b0;
			dack_i  <= 1'b0;
			i_armed = 1'b0;
			d_armed = 1'b0;
			for (int k = 0; k < 64; k++) begin
				dmem[k] = fill_word(32'(k * 4));
			end
		end else begin
			// Instruction bus with 0 to 2 wait cycles
			if (iack_i) begin
				iack_i <= 1'b0;
			end else if (ireq_o) begin
				if (!i_armed) begin
					i_wait  = {$random(seed)} % 3;
					i_armed = 1'b1;
				end
				if (i_wait == 0) begin
					iack_i  <= 1'b1;
					idat_i  <= prog[iaddr_o[7:2]];
					i_armed = 1'b0;
				end else begin
					i_wait = i_wait - 1;
				end
			end
			// Data bus with 0 to 3 wait cycles
			if (dack_i) begin
				dack_i <= 1'b0;
			end else if (dreq_o) begin
				if (!d_armed) begin
					d_wait  = {$random(seed)} % 4;
					d_armed = 1'b1;
				end
				if (d_wait == 0) begin
					dack_i <= 1'b1;
					if (dwe_o) begin
						dmem[daddr_o[7:2]] = dwdat_o;
					end else begin
						drdat_i <= dmem[daddr_o[7:2]];
					end
					d_armed = 1'b0;
				end else begin
					d_wait = d_wait - 1;
				end
			end
		end
	end

	// ------------------------------
	// Store checker
	// ------------------------------
	always @(posedge clk_i) begin
		if (arst_n_i) begin
			// Program's first memory access is a store
			if (dreq_o && !dreq_seen) begin
				dreq_seen = 1'b1;
				check_value("dwe_o", 32'(dwe_o), 32'd1);
			end
			if (dreq_o && dack_i && dwe_o) begin
				if (exp_addr.size() == 0) begin
					$display("Store of %h to %h was not expected", dwdat_o, daddr_o);
					$display("TEST FAIL");
					$fatal(1, "extra store");
				end else begin
					check_value("daddr_o", daddr_o, exp_addr.pop_front());
					check_value("dwdat_o", dwdat_o, exp_data.pop_front());
				end
			end
			if (ireq_o && iack_i && iaddr_o == loop_addr) begin
				loop_fetches++;
			end
		end
	end

	initial begin
		load_program();
		loop_addr = 32'(4 * (prog_len - 1));
		run_model();
		repeat (10) @(posedge clk_i);
		arst_n_i <= 1'b1;
		@(negedge clk_i);
		check_value("ireq_o", 32'(ireq_o), 32'd1);
		check_value("iaddr_o", iaddr_o, RESET_ADDR);
		check_value("dreq_o", 32'(dreq_o), 32'd0);
		cycles = 0;
		while (loop_fetches < 3 && cycles < 40 * prog_len) begin
			@(negedge clk_i);
			cycles++;
		end
		if (loop_fetches < 3) begin
			$display("Timeout after %0d cycles without reaching the final loop",
				cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end else if (exp_addr.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Program ended with %0d expected stores missing", exp_addr.size());
			$display("TEST FAIL");
			$fatal(1, "missing stores");
		end
	end

endmodule

/* titan_core.sv */
/*
 * titan core top level
 * Three-stage RV32I subset pipeline. Connects fetch, decode, execute,
 * the load/store unit and pipeline control to the two memory buses.
 */
`timescale 1ns/10ps

module titan_core (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	// Instruction bus
	output logic [titan_pkg::XLEN-1:0] iaddr_o,
	output logic                       ireq_o,
	input  logic [31:0]                idat_i,
	input  logic                       iack_i,
	// Data bus
	output logic [titan_pkg::XLEN-1:0] daddr_o,
	output logic                       dreq_o,
	output logic                       dwe_o,
	output logic [titan_pkg::XLEN-1:0] dwdat_o,
	input  logic [titan_pkg::XLEN-1:0] drdat_i,
	input  logic                       dack_i
);
	import titan_pkg::*;

	// IF to ID
	logic [XLEN-1:0] id_pc;
	logic [31:0]     id_instr;

	// ID to EX
	logic [XLEN-1:0] ex_pc;
	logic [XLEN-1:0] ex_op_a;
	logic [XLEN-1:0] ex_op_b;
	logic [XLEN-1:0] ex_imm;
	alu_op_e         ex_alu_op;
	logic [4:0]      ex_rd;
	logic            ex_we;
	logic            ex_load;
	logic            ex_store;
	logic [XLEN-1:0] ex_store_data;
	logic            ex_branch;
	logic            ex_branch_ne;
	logic            ex_jump;

	// Writeback and forward
	logic            wb_we;
	logic [4:0]      wb_rd;
	logic [XLEN-1:0] wb_data;

	// EX to LSU
	logic            mem_req;
	logic            mem_we;
	logic [XLEN-1:0] mem_addr;
	logic [XLEN-1:0] mem_wdata;
	logic [XLEN-1:0] mem_rdata;
	logic            mem_stall_req;

	// Control
	logic            take_branch;
	logic [XLEN-1:0] branch_target;
	logic            if_stall_req;
	logic            if_stall;
	logic            id_stall;
	logic            ex_stall;
	logic            if_flush;
	logic            id_flush;

	titan_if_stage if_stage0 (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.if_stall_i     (if_stall),
		.if_flush_i     (if_flush),
		.take_branch_i  (take_branch),
		.branch_target_i(branch_target),
		.iack_i         (iack_i),
		.idat_i         (idat_i),
		.iaddr_o        (iaddr_o),
		.ireq_o         (ireq_o),
		.if_stall_req_o (if_stall_req),
		.id_pc_o        (id_pc),
		.id_instr_o     (id_instr)
	);

	titan_id_stage id_stage0 (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.id_stall_i     (id_stall),
		.id_flush_i     (id_flush),
		.id_pc_i        (id_pc),
		.id_instr_i     (id_instr),
		.wb_we_i        (wb_we),
		.wb_rd_i        (wb_rd),
		.wb_data_i      (wb_data),
		.ex_pc_o        (ex_pc),
		.ex_op_a_o      (ex_op_a),
		.ex_op_b_o      (ex_op_b),
		.ex_imm_o       (ex_imm),
		.ex_alu_op_o    (ex_alu_op),
		.ex_rd_o        (ex_rd),
		.ex_we_o        (ex_we),
		.ex_load_o      (ex_load),
		.ex_store_o     (ex_store),
		.ex_store_data_o(ex_store_data),
		.ex_branch_o    (ex_branch),
		.ex_branch_ne_o (ex_branch_ne),
		.ex_jump_o      (ex_jump)
	);

	titan_ex_stage ex_stage0 (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.ex_stall_i     (ex_stall),
		.ex_pc_i        (ex_pc),
		.ex_op_a_i      (ex_op_a),
		.ex_op_b_i      (ex_op_b),
		.ex_imm_i       (ex_imm),
		.ex_alu_op_i    (ex_alu_op),
		.ex_rd_i        (ex_rd),
		.ex_we_i        (ex_we),
		.ex_load_i      (ex_load),
		.ex_store_i     (ex_store),
		.ex_store_data_i(ex_store_data),
		.ex_branch_i    (ex_branch),
		.ex_branch_ne_i (ex_branch_ne),
		.ex_jump_i      (ex_jump),
		.mem_rdata_i    (mem_rdata),
		.mem_stall_i    (mem_stall_req),
		.mem_req_o      (mem_req),
		.mem_we_o       (mem_we),
		.mem_addr_o     (mem_addr),
		.mem_wdata_o    (mem_wdata),
		.take_branch_o  (take_branch),
		.branch_target_o(branch_target),
		.wb_we_o        (wb_we),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data)
	);

	titan_lsu lsu0 (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.mem_req_i  (mem_req),
		.mem_we_i   (mem_we),
		.mem_addr_i (mem_addr),
		.mem_wdata_i(mem_wdata),
		.drdat_i    (drdat_i),
		.dack_i     (dack_i),
		.mem_rdata_o(mem_rdata),
		.mem_stall_o(mem_stall_req),
		.daddr_o    (daddr_o),
		.dreq_o     (dreq_o),
		.dwe_o      (dwe_o),
		.dwdat_o    (dwdat_o)
	);

	titan_control_unit cu0 (
		.if_stall_req_i (if_stall_req),
		.mem_stall_req_i(mem_stall_req),
		.take_branch_i  (take_branch),
		.if_stall_o     (if_stall),
		.id_stall_o     (id_stall),
		.ex_stall_o     (ex_stall),
		.if_flush_o     (if_flush),
		.id_flush_o     (id_flush)
	);

endmodule

/* titan_control_unit.sv */
/*
 * titan pipeline control
 * Turns the stall requests and the branch redirect into per-stage
 * stall and flush.
 */
`timescale 1ns/10ps

module titan_control_unit (
	input  logic if_stall_req_i,
	input  logic mem_stall_req_i,
	input  logic take_branch_i,
	output logic if_stall_o,
	output logic id_stall_o,
	output logic ex_stall_o,
	output logic if_flush_o,
	output logic id_flush_o
);

	// ------------------------------
	// Stalls
	// ------------------------------
	// Data bus wait freezes the whole pipe
	assign if_stall_o = mem_stall_req_i;
	assign id_stall_o = mem_stall_req_i;
	assign ex_stall_o = mem_stall_req_i;

	// ------------------------------
	// Flushes
	// ------------------------------
	// Missing fetch becomes a bubble in ID, EX keeps running
	assign if_flush_o = ~mem_stall_req_i & (take_branch_i | if_stall_req_i);

	// Wrong-path instruction in decode
	assign id_flush_o = ~mem_stall_req_i & take_branch_i;

endmodule

/* titan_lsu.sv */
/*
 * titan load/store unit
 * Word-only data bus master. Latches one request, holds it on the bus
 * until acknowledge and stalls the pipeline meanwhile.
 */
`timescale 1ns/10ps

module titan_lsu (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic                       mem_req_i,
	input  logic                       mem_we_i,
	input  logic [titan_pkg::XLEN-1:0] mem_addr_i,
	input  logic [titan_pkg::XLEN-1:0] mem_wdata_i,
	input  logic [titan_pkg::XLEN-1:0] drdat_i,
	input  logic                       dack_i,
	output logic [titan_pkg::XLEN-1:0] mem_rdata_o,
	output logic                       mem_stall_o,
	output logic [titan_pkg::XLEN-1:0] daddr_o,
	output logic                       dreq_o,
	output logic                       dwe_o,
	output logic [titan_pkg::XLEN-1:0] dwdat_o
);
	import titan_pkg::*;

	logic            busy_q;
	logic            we_q;
	logic [XLEN-1:0] addr_q;
	logic [XLEN-1:0] wdata_q;

	// Idle then busy until the acknowledge
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
			we_q   <= 1'b0;
		end else if (!busy_q) begin
			busy_q <= mem_req_i;
			we_q   <= mem_req_i & mem_we_i;
		end else if (dack_i) begin
			busy_q <= 1'b0;
			we_q   <= 1'b0;
		end
	end

	// Low address bits dropped, word access only
	always_ff @(posedge clk_i) begin
		if (!busy_q && mem_req_i) begin
			addr_q  <= {mem_addr_i[XLEN-1:2], 2'b00};
			wdata_q <= mem_wdata_i;
		end
	end

	assign dreq_o      = busy_q;
	assign dwe_o       = we_q;
	assign daddr_o     = addr_q;
	assign dwdat_o     = wdata_q;
	assign mem_rdata_o = drdat_i;
	assign mem_stall_o = busy_q ? ~dack_i : mem_req_i;

endmodule

/* titan_ex_stage.sv */
/*
 * titan execute stage
 * ALU, branch and jump resolution, memory request issue and the
 * writeback value selection.
 */
`timescale 1ns/10ps

module titan_ex_stage (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic                       ex_stall_i,
	input  logic [titan_pkg::XLEN-1:0] ex_pc_i,
	input  logic [titan_pkg::XLEN-1:0] ex_op_a_i,
	input  logic [titan_pkg::XLEN-1:0] ex_op_b_i,
	input  logic [titan_pkg::XLEN-1:0] ex_imm_i,
	input  titan_pkg::alu_op_e         ex_alu_op_i,
	input  logic [4:0]                 ex_rd_i,
	input  logic                       ex_we_i,
	input  logic                       ex_load_i,
	input  logic                       ex_store_i,
	input  logic [titan_pkg::XLEN-1:0] ex_store_data_i,
	input  logic                       ex_branch_i,
	input  logic                       ex_branch_ne_i,
	input  logic                       ex_jump_i,
	input  logic [titan_pkg::XLEN-1:0] mem_rdata_i,
	input  logic                       mem_stall_i,
	output logic                       mem_req_o,
	output logic                       mem_we_o,
	output logic [titan_pkg::XLEN-1:0] mem_addr_o,
	output logic [titan_pkg::XLEN-1:0] mem_wdata_o,
	output logic                       take_branch_o,
	output logic [titan_pkg::XLEN-1:0] branch_target_o,
	output logic                       wb_we_o,
	output logic [4:0]                 wb_rd_o,
	output logic [titan_pkg::XLEN-1:0] wb_data_o
);
	import titan_pkg::*;

	logic [XLEN-1:0] alu_res;
	logic            equal;
	logic            done_q;

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb begin
		case (ex_alu_op_i)
			ALU_ADD:    alu_res = ex_op_a_i + ex_op_b_i;
			ALU_SUB:    alu_res = ex_op_a_i - ex_op_b_i;
			ALU_AND:    alu_res = ex_op_a_i & ex_op_b_i;
			ALU_OR:     alu_res = ex_op_a_i | ex_op_b_i;
			ALU_XOR:    alu_res = ex_op_a_i ^ ex_op_b_i;
			ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(ex_op_a_i) < $signed(ex_op_b_i)};
			ALU_PASS_B: alu_res = ex_op_b_i;
			default:    alu_res = '0;
		endcase
	end

	// BEQ/BNE differ only in the sense of the compare
	assign equal           = (ex_op_a_i == ex_op_b_i);
	assign take_branch_o   = ex_jump_i | (ex_branch_i & (equal ^ ex_branch_ne_i));
	assign branch_target_o = ex_pc_i + ex_imm_i;

	// ------------------------------
	// Memory access
	// ------------------------------
	// Single issue per instruction, held off once sent
	assign mem_req_o   = (ex_load_i | ex_store_i) & ~done_q;
	assign mem_we_o    = ex_store_i;
	assign mem_addr_o  = ex_op_a_i + ex_imm_i;
	assign mem_wdata_o = ex_store_data_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_q <= 1'b0;
		end else if (!ex_stall_i) begin
			done_q <= 1'b0;
		end else if (mem_req_o) begin
			done_q <= 1'b1;
		end
	end

	// Writeback lands at the end of the EX cycle
	assign wb_we_o   = ex_we_i & ~mem_stall_i;
	assign wb_rd_o   = ex_rd_i;
	assign wb_data_o = ex_load_i ? mem_rdata_i :
			ex_jump_i ? ex_pc_i + XLEN'(4) : alu_res;

endmodule

/* titan_id_stage.sv */
/*
 * titan decode stage
 * Decodes the instruction, builds the immediate, reads the register
 * file with writeback bypass and loads the ID/EX register.
 */
`timescale 1ns/10ps

module titan_id_stage (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic                       id_stall_i,
	input  logic                       id_flush_i,
	input  logic [titan_pkg::XLEN-1:0] id_pc_i,
	input  logic [31:0]                id_instr_i,
	input  logic                       wb_we_i,
	input  logic [4:0]                 wb_rd_i,
	input  logic [titan_pkg::XLEN-1:0] wb_data_i,
	output logic [titan_pkg::XLEN-1:0] ex_pc_o,
	output logic [titan_pkg::XLEN-1:0] ex_op_a_o,
	output logic [titan_pkg::XLEN-1:0] ex_op_b_o,
	output logic [titan_pkg::XLEN-1:0] ex_imm_o,
	output titan_pkg::alu_op_e         ex_alu_op_o,
	output logic [4:0]                 ex_rd_o,
	output logic                       ex_we_o,
	output logic                       ex_load_o,
	output logic                       ex_store_o,
	output logic [titan_pkg::XLEN-1:0] ex_store_data_o,
	output logic                       ex_branch_o,
	output logic                       ex_branch_ne_o,
	output logic                       ex_jump_o
);
	import titan_pkg::*;

	instr_u          ins;
	logic [XLEN-1:0] regs [32];
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] op_b;
	alu_op_e         f3_op;
	alu_op_e         alu_op;
	logic            we;
	logic            load;
	logic            store;
	logic            branch;
	logic            jump;

	assign ins = id_instr_i;

	// ------------------------------
	// Immediates
	// ------------------------------
	assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
	assign imm_s = {{20{ins.raw[31]}}, ins.raw[31:25], ins.raw[11:7]};
	assign imm_b = {{19{ins.raw[31]}}, ins.raw[31], ins.raw[7], ins.raw[30:25],
			ins.raw[11:8], 1'b0};
	assign imm_j = {{11{ins.raw[31]}}, ins.raw[31], ins.raw[19:12], ins.raw[20],
			ins.raw[30:21], 1'b0};
	assign imm_u = {ins.raw[31:12], 12'h000};

	// Register file, x0 reads as zero, bypass from EX
	assign rs1_val = (ins.r.rs1 == 5'd0) ? '0 :
			(wb_we_i && wb_rd_i == ins.r.rs1) ? wb_data_i : regs[ins.r.rs1];
	assign rs2_val = (ins.r.rs2 == 5'd0) ? '0 :
			(wb_we_i && wb_rd_i == ins.r.rs2) ? wb_data_i : regs[ins.r.rs2];

	always_ff @(posedge clk_i) begin
		if (wb_we_i && wb_rd_i != 5'd0) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

	// ------------------------------
	// Decoder
	// ------------------------------
	always_comb begin
		case (ins.i.funct3)
			3'b010:  f3_op = ALU_SLT;
			3'b100:  f3_op = ALU_XOR;
			3'b110:  f3_op = ALU_OR;
			3'b111:  f3_op = ALU_AND;
			default: f3_op = ALU_ADD;
		endcase
	end

	always_comb begin
		imm    = imm_i;
		op_b   = imm_i;
		alu_op = ALU_ADD;
		we     = 1'b0;
		load   = 1'b0;
		store  = 1'b0;
		branch = 1'b0;
		jump   = 1'b0;
		case (ins.r.opcode)
			OPC_LUI: begin
				imm    = imm_u;
				op_b   = imm_u;
				alu_op = ALU_PASS_B;
				we     = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op = f3_op;
				we     = 1'b1;
			end
			OPC_OP: begin
				op_b   = rs2_val;
				alu_op = (ins.i.funct3 == 3'b000 && ins.r.funct7[5]) ? ALU_SUB : f3_op;
				we     = 1'b1;
			end
			OPC_BRANCH: begin
				imm    = imm_b;
				op_b   = rs2_val;
				branch = 1'b1;
			end
			OPC_JAL: begin
				imm  = imm_j;
				jump = 1'b1;
				we   = 1'b1;
			end
			OPC_LOAD: begin
				load = 1'b1;
				we   = 1'b1;
			end
			OPC_STORE: begin
				imm   = imm_s;
				store = 1'b1;
			end
			default: begin
				we = 1'b0;
			end
		endcase
	end

	// ------------------------------
	// ID/EX register
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_we_o     <= 1'b0;
			ex_load_o   <= 1'b0;
			ex_store_o  <= 1'b0;
			ex_branch_o <= 1'b0;
			ex_jump_o   <= 1'b0;
		end else if (!id_stall_i) begin
			ex_we_o     <= we & ~id_flush_i;
			ex_load_o   <= load & ~id_flush_i;
			ex_store_o  <= store & ~id_flush_i;
			ex_branch_o <= branch & ~id_flush_i;
			ex_jump_o   <= jump & ~id_flush_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!id_stall_i) begin
			ex_pc_o         <= id_pc_i;
			ex_op_a_o       <= rs1_val;
			ex_op_b_o       <= op_b;
			ex_imm_o        <= imm;
			ex_alu_op_o     <= alu_op;
			ex_rd_o         <= ins.r.rd;
			ex_store_data_o <= rs2_val;
			ex_branch_ne_o  <= ins.i.funct3[0];
		end
	end

endmodule

/* titan_if_stage.sv */
/*
 * titan fetch stage
 * Program counter, instruction bus requester and the IF/ID register.
 * A word that arrives during a freeze is parked in a holding register,
 * and a redirect seen mid-fetch waits for the acknowledge first.
 */
`timescale 1ns/10ps

module titan_if_stage (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic                       if_stall_i,
	input  logic                       if_flush_i,
	input  logic                       take_branch_i,
	input  logic [titan_pkg::XLEN-1:0] branch_target_i,
	input  logic                       iack_i,
	input  logic [31:0]                idat_i,
	output logic [titan_pkg::XLEN-1:0] iaddr_o,
	output logic                       ireq_o,
	output logic                       if_stall_req_o,
	output logic [titan_pkg::XLEN-1:0] id_pc_o,
	output logic [31:0]                id_instr_o
);
	import titan_pkg::*;

	logic [XLEN-1:0] pc_q;
	logic            redir_pend_q;
	logic [XLEN-1:0] redir_pc_q;
	logic            held_valid_q;
	logic [31:0]     held_instr_q;
	logic [XLEN-1:0] held_pc_q;
	logic            fetch_done;
	logic            word_ok;

	// No new request while a word is parked
	assign ireq_o     = ~held_valid_q;
	assign iaddr_o    = pc_q;
	assign fetch_done = ireq_o & iack_i;

	// Word from a stale fetch is dropped
	assign word_ok        = fetch_done & ~redir_pend_q;
	assign if_stall_req_o = ~(held_valid_q | word_ok);

	// ------------------------------
	// PC and pending redirect
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q         <= RESET_ADDR;
			redir_pend_q <= 1'b0;
		end else if (take_branch_i) begin
			// Request must stay steady until its acknowledge
			if (ireq_o && !iack_i) begin
				redir_pend_q <= 1'b1;
			end else begin
				pc_q <= branch_target_i;
			end
		end else if (fetch_done) begin
			redir_pend_q <= 1'b0;
			pc_q         <= redir_pend_q ? redir_pc_q : pc_q + XLEN'(4);
		end
	end

	always_ff @(posedge clk_i) begin
		if (take_branch_i) begin
			redir_pc_q <= branch_target_i;
		end
	end

	// ------------------------------
	// Holding register
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			held_valid_q <= 1'b0;
		end else if (take_branch_i) begin
			held_valid_q <= 1'b0;
		end else if (held_valid_q) begin
			held_valid_q <= if_stall_i;
		end else begin
			held_valid_q <= word_ok & if_stall_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!held_valid_q && word_ok) begin
			held_instr_q <= idat_i;
			held_pc_q    <= pc_q;
		end
	end

	// ------------------------------
	// IF/ID register
	// ------------------------------
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_instr_o <= NOP_INSTR;
			id_pc_o    <= RESET_ADDR;
		end else if (!if_stall_i) begin
			// Flush also covers a fetch that is still waiting
			if (if_flush_i) begin
				id_instr_o <= NOP_INSTR;
			end else if (held_valid_q) begin
				id_instr_o <= held_instr_q;
				id_pc_o    <= held_pc_q;
			end else begin
				id_instr_o <= idat_i;
				id_pc_o    <= pc_q;
			end
		end
	end

endmodule

/* titan_pkg.sv */
/*
 * titan core shared definitions
 * Data width, reset address, RV32I major opcodes, ALU operation
 * codes and the two field views of the instruction word.
 */
package titan_pkg;

	localparam int XLEN = 32;

	// First fetch after reset
	localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000;

	// ------------------------------
	// Major opcodes
	// ------------------------------
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// ADDI x0, x0, 0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

	// ------------------------------
	// ALU operations
	// ------------------------------
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_PASS_B = 4'd6
	} alu_op_e;

	// Register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_r_s;

	// Immediate layout
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} instr_i_s;

	// One word, two field views, plus the raw bits for the odd immediates
	typedef union packed {
		instr_r_s    r;
		instr_i_s    i;
		logic [31:0] raw;
	} instr_u;

endpackage
